/* list.f */
verilog/dbg_pkg.sv
verilog/dump_beat_if.sv
verilog/dump_sequencer.sv
verilog/slot_map_serializer.sv
verilog/rom_table_serializer.sv
verilog/ddr_byte_writer.sv
verilog/config_dump.sv
sim/clock_gen.sv
sim/tb_config_dump.sv

/* sim/clock_gen.sv */
module clock_gen (
   output logic clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   // 40 ns period.
   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
   end

endmodule

/* sim/tb_config_dump.sv */
module tb_config_dump;

   timeunit 1ns;
   timeprecision 100ps;

   localparam dbg_pkg::ddr_addr_t dump_base = 28'h2a45d38;
   localparam int num_rows  = 3;
   localparam int num_spots = 4;
   localparam int max_run   = 4;
   localparam int timeout_limit = num_rows * 2048 * (4 + max_run) + 2000;

   logic                 clk;
   logic                 reset;
   logic                 snapshot = 1'b0;
   logic                 ddr3_ready = 1'b1;
   dbg_pkg::slot_entry_t slot_map [64];
   dbg_pkg::byte_t       slot_type [4];
   dbg_pkg::block_desc_t block_table [16];
   dbg_pkg::rom_desc_t   rom_table [2];
   dbg_pkg::ddr_addr_t   ddr3_addr;
   dbg_pkg::byte_t       ddr3_din;
   logic                 ddr3_upload;
   logic                 ddr3_wr;
   logic                 dump_busy;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Scenario table
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   int row_seed  [num_rows] = '{0, 7, 19};
   int row_stall [num_rows] = '{0, 30, 70};
   // ROM 0 is always loaded, ROM 1 never, the rest are padding.
   dbg_pkg::dump_index_t spot_index [num_rows][num_spots] = '{
      '{11'h205, 11'h215, 11'h084, 11'h30f},
      '{11'h205, 11'h206, 11'h10f, 11'h7ff},
      '{11'h205, 11'h220, 11'h1f5, 11'h0ff}
   };
   dbg_pkg::byte_t spot_value [num_rows][num_spots] = '{
      '{8'h01, 8'h00, 8'h00, 8'h00},
      '{8'h01, 8'h00, 8'h00, 8'h00},
      '{8'h01, 8'h00, 8'h00, 8'h00}
   };

   dbg_pkg::byte_t model_mem [dbg_pkg::ddr_addr_t];
   int             write_count = 0;
   int             cur_row = 0;
   int             value_errors = 0;
   int             other_errors = 0;
   int             cycle_count = 0;
   logic [31:0]    stall_state = 32'd41;
   int             stall_left = 0;

   clock_gen u_clock (
      .clk   (clk),
      .reset (reset)
   );

   config_dump #(
      .DUMP_BASE (dump_base)
   ) u_dut (
      .clk         (clk),
      .reset       (reset),
      .snapshot    (snapshot),
      .slot_map    (slot_map),
      .slot_type   (slot_type),
      .block_table (block_table),
      .rom_table   (rom_table),
      .ddr3_ready  (ddr3_ready),
      .ddr3_addr   (ddr3_addr),
      .ddr3_din    (ddr3_din),
      .ddr3_upload (ddr3_upload),
      .ddr3_wr     (ddr3_wr),
      .dump_busy   (dump_busy)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1664525 + 32'd1013904223;
   endfunction

   // Expected dump byte for one index.
   function automatic dbg_pkg::byte_t expected_byte(input dbg_pkg::dump_index_t idx);
      int                   off;
      int                   k;
      dbg_pkg::slot_entry_t e;
      dbg_pkg::block_desc_t b;
      dbg_pkg::rom_desc_t   r;
      dbg_pkg::byte_t       result;
      off = idx % 256;
      k = off % 16;
      result = 8'h00;
      if (idx / 256 == 0) begin
         e = slot_map[off / 2];
         if (off < 128) begin
            result = (off % 2 == 0) ? e[11:4] : {e[3:0], 4'h0};
         end else if (off < 132) begin
            result = slot_type[off - 128];
         end
      end else if (idx / 256 == 1) begin
         b = block_table[off / 16];
         case (k)
            0: result = {6'b000000, b[33:32]};
            1: result = b[31:24];
            2: result = b[23:16];
            3: result = b[15:8];
            4: result = b[7:0];
            default: result = 8'h00;
         endcase
      end else if (idx / 256 == 2 && off < 32) begin
         r = rom_table[off / 16];
         case (k)
            0: result = r[47:40];
            1: result = r[39:32];
            2: result = r[31:24];
            3: result = r[23:16];
            4: result = r[15:8];
            5: result = r[7:0];
            default: result = 8'h00;
         endcase
      end
      return result;
   endfunction

   task automatic check_byte(input string name, input dbg_pkg::byte_t exp,
                             input dbg_pkg::byte_t act);
      if (act !== exp) begin
         $display("FAIL %s expected %02h actual %02h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_addr(input string name, input dbg_pkg::ddr_addr_t exp,
                             input dbg_pkg::ddr_addr_t act);
      if (act !== exp) begin
         $display("FAIL %s expected %07h actual %07h", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s expected %b actual %b", name, exp, act);
         value_errors++;
      end
   endtask

   task automatic check_count(input string name, input int exp, input int act);
      if (act != exp) begin
         $display("FAIL %s expected %0d actual %0d", name, exp, act);
         value_errors++;
      end
   endtask

   // Called right after a rising edge.
   task automatic fill_tables(input int seed);
      logic [31:0] s;
      logic [31:0] hi;
      s = 32'd41 + seed;
      for (int i = 0; i < 64; i++) begin
         s = lcg_next(s);
         slot_map[i] <= s[27:16];
      end
      for (int i = 0; i < 4; i++) begin
         s = lcg_next(s);
         slot_type[i] <= s[23:16];
      end
      for (int i = 0; i < 16; i++) begin
         hi = lcg_next(s);
         s = lcg_next(hi);
         block_table[i] <= {hi[25:16], s[31:8]};
      end
      for (int i = 0; i < 2; i++) begin
         hi = lcg_next(s);
         s = lcg_next(hi);
         rom_table[i] <= {hi[31:16], s[31:8], (i == 0) ? 8'h01 : 8'h00};
      end
   endtask

   task automatic pulse_snapshot();
      @(posedge clk);
      snapshot <= 1'b1;
      @(posedge clk);
      snapshot <= 1'b0;
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Ready stalls, capture and timeout
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Every low run is 1 to max_run cycles, with a high cycle before it.
   always @(posedge clk) begin
      stall_state = lcg_next(stall_state);
      if (stall_left > 0) begin
         ddr3_ready <= 1'b0;
         stall_left = stall_left - 1;
      end else begin
         ddr3_ready <= 1'b1;
         if (stall_state[31:16] % 100 < row_stall[cur_row]) begin
            stall_left = 1 + stall_state[23:22];
         end
      end
   end

   always @(negedge clk) begin
      if (!reset && ddr3_wr) begin
         check_flag("ready at write", 1'b1, ddr3_ready);
         check_flag("upload at write", 1'b1, ddr3_upload);
         check_addr($sformatf("row %0d write %0d address", cur_row, write_count),
                    dump_base + dbg_pkg::ddr_addr_t'(write_count), ddr3_addr);
         if (model_mem.exists(ddr3_addr)) begin
            $display("ERROR: address %07h written twice in row %0d", ddr3_addr, cur_row);
            other_errors++;
         end
         model_mem[ddr3_addr] = ddr3_din;
         write_count++;
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > timeout_limit) begin
         $display("ERROR: timeout after %0d cycles, dump did not finish", cycle_count);
         $display("Simulation FAILED");
         $finish;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Scenario loop
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   initial begin
      dbg_pkg::ddr_addr_t addr;
      foreach (slot_map[i]) slot_map[i] = '0;
      foreach (slot_type[i]) slot_type[i] = '0;
      foreach (block_table[i]) block_table[i] = '0;
      foreach (rom_table[i]) rom_table[i] = '0;
      for (int row = 0; row < num_rows; row++) begin
         cur_row = row;
         model_mem.delete();
         write_count = 0;
         @(posedge clk);
         fill_tables(row_seed[row]);
         if (row == 0) begin
            // Automatic dump after reset.
            @(negedge clk);
            check_flag("wr low in reset", 1'b0, ddr3_wr);
            check_flag("upload low in reset", 1'b0, ddr3_upload);
            while (reset) @(negedge clk);
         end else begin
            pulse_snapshot();
            @(negedge clk);
         end
         check_flag($sformatf("row %0d busy at start", row), 1'b1, dump_busy);
         while (write_count < 100) @(negedge clk);
         pulse_snapshot();
         while (dump_busy) @(negedge clk);
         check_flag($sformatf("row %0d upload after dump", row), 1'b0, ddr3_upload);
         check_count($sformatf("row %0d write count", row), 2048, write_count);
         for (int idx = 0; idx < 2048; idx++) begin
            addr = dump_base + dbg_pkg::ddr_addr_t'(idx);
            if (!model_mem.exists(addr)) begin
               $display("ERROR: row %0d has no write at address %07h", row, addr);
               other_errors++;
            end else begin
               check_byte($sformatf("row %0d index %03h", row, idx),
                          expected_byte(dbg_pkg::dump_index_t'(idx)), model_mem[addr]);
            end
         end
         for (int s = 0; s < num_spots; s++) begin
            addr = dump_base + dbg_pkg::ddr_addr_t'(spot_index[row][s]);
            if (model_mem.exists(addr)) begin
               check_byte($sformatf("row %0d spot %03h", row, spot_index[row][s]),
                          spot_value[row][s], model_mem[addr]);
            end
         end
      end
      $display("Errors: %0d value mismatches, %0d other failures", value_errors,
               other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

/* verilog/config_dump.sv */
module config_dump #(
   parameter dbg_pkg::ddr_addr_t DUMP_BASE = 28'h1400000
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 snapshot,
   input  dbg_pkg::slot_entry_t slot_map [64],
   input  dbg_pkg::byte_t       slot_type [4],
   input  dbg_pkg::block_desc_t block_table [16],
   input  dbg_pkg::rom_desc_t   rom_table [2],
   input  logic                 ddr3_ready,
   output dbg_pkg::ddr_addr_t   ddr3_addr,
   output dbg_pkg::byte_t       ddr3_din,
   output logic                 ddr3_upload,
   output logic                 ddr3_wr,
   output logic                 dump_busy
);

   dbg_pkg::byte_t   slot_byte;
   dbg_pkg::byte_t   slot_offset;
   dbg_pkg::byte_t   table_byte;
   dbg_pkg::byte_t   table_offset;
   dbg_pkg::region_t table_region;
   logic             upload;

   dump_beat_if beat ();

   dump_sequencer u_sequencer (
      .clk          (clk),
      .reset        (reset),
      .snapshot     (snapshot),
      .slot_byte    (slot_byte),
      .slot_offset  (slot_offset),
      .table_byte   (table_byte),
      .table_offset (table_offset),
      .table_region (table_region),
      .beat         (beat),
      .upload       (upload),
      .dump_busy    (dump_busy)
   );

   slot_map_serializer u_slot_map (
      .slot_map  (slot_map),
      .slot_type (slot_type),
      .offset    (slot_offset),
      .data      (slot_byte)
   );

   rom_table_serializer u_rom_table (
      .region      (table_region),
      .block_table (block_table),
      .rom_table   (rom_table),
      .offset      (table_offset),
      .data        (table_byte)
   );

   ddr_byte_writer #(
      .DUMP_BASE (DUMP_BASE)
   ) u_writer (
      .clk         (clk),
      .reset       (reset),
      .beat        (beat),
      .upload      (upload),
      .ddr3_ready  (ddr3_ready),
      .ddr3_addr   (ddr3_addr),
      .ddr3_din    (ddr3_din),
      .ddr3_upload (ddr3_upload),
      .ddr3_wr     (ddr3_wr)
   );

endmodule

/* verilog/dbg_pkg.sv */
package dbg_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Data widths
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   typedef logic [7:0]  byte_t;

   // Bits 10:8 select the region, bits 7:0 the offset within it.
   typedef logic [10:0] dump_index_t;

   typedef logic [27:0] ddr_addr_t;

   // Byte 0 is bits 11:4, byte 1 is bits 3:0 padded with zeros.
   typedef logic [11:0] slot_entry_t;

   // Block count [33:24], memory offset [23:0].
   typedef logic [33:0] block_desc_t;

   // Mapper [47:40], offset [39:32], size [31:8], loaded [7:0].
   typedef logic [47:0] rom_desc_t;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Enumerations
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Regions 3 to 7 all map onto region_empty.
   typedef enum logic [2:0] {
      region_slot  = 3'd0,
      region_block = 3'd1,
      region_rom   = 3'd2,
      region_empty = 3'd3
   } region_t;

   typedef enum logic [1:0] {
      st_idle    = 2'd0,
      st_fetch   = 2'd1,
      st_write   = 2'd2,
      st_advance = 2'd3
   } seq_state_t;

endpackage

/* verilog/ddr_byte_writer.sv */
module ddr_byte_writer #(
   parameter dbg_pkg::ddr_addr_t DUMP_BASE = 28'h1400000
) (
   input  logic               clk,
   input  logic               reset,
   dump_beat_if.writer        beat,
   input  logic               upload,
   input  logic               ddr3_ready,
   output dbg_pkg::ddr_addr_t ddr3_addr,
   output dbg_pkg::byte_t     ddr3_din,
   output logic               ddr3_upload,
   output logic               ddr3_wr
);

   logic pending;
   logic done_r;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Handshake with the DDR3 port
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   // Write fires in the first cycle with ready while a byte waits.
   assign ddr3_wr = pending & ddr3_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending     <= 1'b0;
         done_r      <= 1'b0;
         ddr3_upload <= 1'b0;
      end else begin
         ddr3_upload <= upload;
         done_r      <= ddr3_wr;
         if (beat.load) begin
            pending <= 1'b1;
         end else if (ddr3_wr) begin
            pending <= 1'b0;
         end
      end
   end

   // Byte and address hold until the next load.
   always_ff @(posedge clk) begin
      if (beat.load) begin
         ddr3_din  <= beat.data;
         ddr3_addr <= DUMP_BASE + dbg_pkg::ddr_addr_t'(beat.index);
      end
   end

   assign beat.done = done_r;

endmodule

/* verilog/dump_beat_if.sv */
interface dump_beat_if;

   logic                 load;
   dbg_pkg::byte_t       data;
   dbg_pkg::dump_index_t index;
   logic                 done;

   // Data and index are only valid while load is high.
   modport sequencer (
      output load,
      output data,
      output index,
      input  done
   );

   modport writer (
      input  load,
      input  data,
      input  index,
      output done
   );

endinterface

/* verilog/dump_sequencer.sv */
module dump_sequencer (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 snapshot,
   input  dbg_pkg::byte_t       slot_byte,
   output dbg_pkg::byte_t       slot_offset,
   input  dbg_pkg::byte_t       table_byte,
   output dbg_pkg::byte_t       table_offset,
   output dbg_pkg::region_t     table_region,
   dump_beat_if.sequencer       beat,
   output logic                 upload,
   output logic                 dump_busy
);

   localparam dbg_pkg::dump_index_t last_index = 11'h7ff;

   dbg_pkg::seq_state_t  state;
   dbg_pkg::dump_index_t index;
   dbg_pkg::region_t     region;
   logic                 last_byte;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Dump FSM
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   assign last_byte = (index == last_index);

   // Reset lands in fetch so the first dump runs on its own.
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= dbg_pkg::st_fetch;
         index <= '0;
      end else begin
         case (state)
            dbg_pkg::st_idle: begin
               if (snapshot) begin
                  state <= dbg_pkg::st_fetch;
                  index <= '0;
               end
            end
            dbg_pkg::st_fetch: state <= dbg_pkg::st_write;
            dbg_pkg::st_write: begin
               if (beat.done) begin
                  state <= dbg_pkg::st_advance;
               end
            end
            dbg_pkg::st_advance: begin
               if (last_byte) begin
                  state <= dbg_pkg::st_idle;
               end else begin
                  index <= index + 11'd1;
                  state <= dbg_pkg::st_fetch;
               end
            end
            default: state <= dbg_pkg::st_idle;
         endcase
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Region decode and byte select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      case (index[10:8])
         3'd0:    region = dbg_pkg::region_slot;
         3'd1:    region = dbg_pkg::region_block;
         3'd2:    region = dbg_pkg::region_rom;
         default: region = dbg_pkg::region_empty;
      endcase
   end

   assign slot_offset  = index[7:0];
   assign table_offset = index[7:0];
   assign table_region = region;

   always_comb begin
      case (region)
         dbg_pkg::region_slot:  beat.data = slot_byte;
         dbg_pkg::region_block,
         dbg_pkg::region_rom:   beat.data = table_byte;
         default:               beat.data = 8'h00;
      endcase
   end

   assign beat.load  = (state == dbg_pkg::st_fetch);
   assign beat.index = index;

   // Upload drops during the advance after the final byte.
   assign dump_busy = (state != dbg_pkg::st_idle);
   assign upload    = dump_busy && !(state == dbg_pkg::st_advance && last_byte);

endmodule

/* verilog/rom_table_serializer.sv */
module rom_table_serializer (
   input  dbg_pkg::region_t     region,
   input  dbg_pkg::block_desc_t block_table [16],
   input  dbg_pkg::rom_desc_t   rom_table [2],
   input  dbg_pkg::byte_t       offset,
   output dbg_pkg::byte_t       data
);

   dbg_pkg::block_desc_t blk;
   logic [9:0]           blk_count;
   logic [23:0]          blk_offset;
   dbg_pkg::rom_desc_t   rom;
   dbg_pkg::byte_t       blk_byte;
   dbg_pkg::byte_t       rom_byte;

   // Sixteen bytes per block entry.
   assign blk        = block_table[offset[7:4]];
   assign blk_count  = blk[33:24];
   assign blk_offset = blk[23:0];

   // Two ROM halves of sixteen bytes each.
   assign rom = rom_table[offset[4]];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Field layouts
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      case (offset[3:0])
         4'd0:    blk_byte = {6'b000000, blk_count[9:8]};
         4'd1:    blk_byte = blk_count[7:0];
         4'd2:    blk_byte = blk_offset[23:16];
         4'd3:    blk_byte = blk_offset[15:8];
         4'd4:    blk_byte = blk_offset[7:0];
         default: blk_byte = 8'h00;
      endcase
   end

   always_comb begin
      if (offset[7:5] != 3'd0) begin
         rom_byte = 8'h00;
      end else begin
         case (offset[3:0])
            4'd0:    rom_byte = rom[47:40];
            4'd1:    rom_byte = rom[39:32];
            4'd2:    rom_byte = rom[31:24];
            4'd3:    rom_byte = rom[23:16];
            4'd4:    rom_byte = rom[15:8];
            4'd5:    rom_byte = rom[7:0];
            default: rom_byte = 8'h00;
         endcase
      end
   end

   always_comb begin
      case (region)
         dbg_pkg::region_block: data = blk_byte;
         dbg_pkg::region_rom:   data = rom_byte;
         default:               data = 8'h00;
      endcase
   end

endmodule

/* verilog/slot_map_serializer.sv */
module slot_map_serializer (
   input  dbg_pkg::slot_entry_t slot_map [64],
   input  dbg_pkg::byte_t       slot_type [4],
   input  dbg_pkg::byte_t       offset,
   output dbg_pkg::byte_t       data
);

   logic [1:0]           slot;
   logic [1:0]           subslot;
   logic [1:0]           page;
   logic [5:0]           entry_num;
   dbg_pkg::slot_entry_t entry;

   // Two bytes per entry, so the entry number sits above bit 0.
   assign slot      = offset[6:5];
   assign subslot   = offset[4:3];
   assign page      = offset[2:1];
   assign entry_num = {slot, subslot, page};
   assign entry     = slot_map[entry_num];

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Byte select
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

   always_comb begin
      if (!offset[7]) begin
         if (offset[0]) begin
            data = {entry[3:0], 4'b0000};
         end else begin
            data = entry[11:4];
         end
      end else if (offset[6:2] == 5'd0) begin
         // Slot types at 128 to 131.
         data = slot_type[offset[1:0]];
      end else begin
         data = 8'h00;
      end
   end

endmodule
